// File: files.f
+incdir+testbench
source/spiPkg.sv
source/memPkg.sv
source/spiCtrlIf.sv
source/spiInputSync.sv
source/bitCounter.sv
source/shiftRegister.sv
source/dataMemory.sv
source/spiFsm.sv
source/spiMemoryTop.sv
testbench/tbSpiMemory.sv

// File: testbench/spiTasks.svh
// SPI master side, mode 0, MSB first
// Every task starts and ends on a rising clk edge

task automatic waitCycles(input int n);
  for (int c = 0; c < n; c++) begin
    @(posedge clk);
  end
endtask

// Read path only, after fall 8; returns rising edges spent
task automatic waitEnableHigh(output int used);
  used = 0;
  @(negedge clk);
  while (!misoEnable && used < enableLimit) begin
    @(negedge clk);
    used++;
  end
  if (!misoEnable) begin
    timeouts++;
    $display("Timeout at %0t: misoEnable never rose after the read flag", $time);
  end
  @(posedge clk);  // Back on the drive edge
  used++;
endtask

// Rest of a low phase, slave sampled half a cycle before the rise
task automatic finishLow(input int rest, output logic misoNow, output logic enableNow);
  waitCycles(rest - 1);
  @(negedge clk);
  misoNow   = miso;
  enableNow = misoEnable;
  @(posedge clk);
endtask

function automatic logic [15:0] makeFrame(input memPkg::memAddr addr, input logic rw,
                                          input memPkg::memWord data);
  return {addr, rw, data};  // Address bits 1 to 7, flag bit 8
endfunction

// One chip-select frame with any number of sclk pulses
task automatic runFrame(input logic [15:0] txFrame, input int pulses,
                        output memPkg::memWord rxWord);
  logic isRead;
  logic misoNow;
  logic enableNow;
  int   used;
  isRead     = txFrame[8];
  rxWord     = '0;
  enableSeen = 1'b0;
  csN  <= 1'b0;
  mosi <= txFrame[frameLen - 1];  // First bit ready before rise 1
  for (int i = 0; i < pulses; i++) begin
    used = 0;
    if (isRead && i == dataStart) begin
      waitEnableHigh(used);
    end
    finishLow(halfPeriod - used, misoNow, enableNow);
    if (isRead && i >= dataStart && i < frameLen) begin
      rxWord[frameLen - 1 - i] = misoNow;  // MSB arrives first
      if (!enableNow) begin
        errors++;
        $display("FAILED at %0t: misoEnable low before rise %0d", $time, i + 1);
      end
    end
    sclk <= 1'b1;
    waitCycles(halfPeriod);
    sclk <= 1'b0;
    if (i + 1 < frameLen) begin
      mosi <= txFrame[frameLen - 2 - i];
    end else begin
      mosi <= ($urandom_range(1) == 1);  // Junk past bit 16
    end
  end
  finishLow(halfPeriod, misoNow, enableNow);
  if (isRead && pulses >= frameLen && enableNow) begin
    errors++;
    $display("FAILED at %0t: misoEnable still high after the last fall", $time);
  end
  csN  <= 1'b1;
  mosi <= 1'b0;
  waitCycles(halfPeriod);  // Gap so the FSM is back in idle
  if (!isRead && enableSeen) begin
    errors++;
    $display("FAILED at %0t: misoEnable rose during a write frame", $time);
  end
endtask

// Short frames are dropped, so only full ones reach the reference
task automatic writeWord(input memPkg::memAddr addr, input memPkg::memWord data,
                         input int pulses);
  memPkg::memWord rx;
  runFrame(makeFrame(addr, 1'b0, data), pulses, rx);
  if (pulses >= frameLen) begin
    refMem[addr] = data;
  end
endtask

task automatic readAndCheck(input memPkg::memAddr addr);
  memPkg::memWord rx;
  runFrame(makeFrame(addr, 1'b1, 8'h00), frameLen, rx);
  if (rx !== refMem[addr]) begin
    errors++;
    $display("FAILED at %0t: read of address %02h gave %02h, expected %02h",
             $time, addr, rx, refMem[addr]);
  end
endtask

// File: testbench/tbSpiMemory.sv
`timescale 1ns/1ps

module tbSpiMemory;

  localparam int halfPeriod  = 10;              // clk cycles per sclk half period
  localparam int enableLimit = halfPeriod - 2;  // Room left for the rest of the low phase
  localparam int frameLen    = 16;              // Address, flag, data byte
  localparam int dataStart   = 8;               // First data bit, counted from 0

  logic clk = 1'b0;
  logic reset;
  logic sclk;
  logic csN;
  logic mosi;
  logic miso;
  logic misoEnable;

  // Words the master has written so far
  memPkg::memWord refMem [memPkg::memDepth];

  int errors;    // Wrong values
  int timeouts;  // Waits that ran out
  bit enableSeen;  // Set when misoEnable is high at any negedge

  spiMemoryTop spiMemoryTop_inst (
    .clk        (clk),
    .reset      (reset),
    .sclk       (sclk),
    .csN        (csN),
    .mosi       (mosi),
    .miso       (miso),
    .misoEnable (misoEnable)
  );

  // 20 ns period
  always #10 clk = ~clk;

  // Watch the enable between drive edges
  always @(negedge clk) begin
    if (misoEnable === 1'b1) begin
      enableSeen = 1'b1;
    end
  end

  `include "spiTasks.svh"

  // Bus stays quiet, no clocks touch misoEnable
  task automatic testIdleBus();
    enableSeen = 1'b0;
    for (int p = 0; p < 8; p++) begin
      mosi <= ($urandom_range(1) == 1);
      sclk <= 1'b1;
      waitCycles(halfPeriod);
      sclk <= 1'b0;
      waitCycles(halfPeriod);
    end
    if (enableSeen) begin
      errors++;
      $display("FAILED at %0t: misoEnable rose with csN high", $time);
    end
  endtask

  task automatic testWriteRead();
    writeWord(7'h2A, 8'hA5, frameLen);
    readAndCheck(7'h2A);
  endtask

  // Twenty random words, one overwrite, then read everything back
  task automatic testRandomWrites();
    memPkg::memAddr addrList [$];
    memPkg::memAddr addr;
    memPkg::memWord data;
    for (int n = 0; n < 20; n++) begin
      addr = memPkg::memAddr'($urandom_range(memPkg::memDepth - 1));
      data = memPkg::memWord'($urandom);
      writeWord(addr, data, frameLen);
      addrList.push_back(addr);
    end
    writeWord(addrList[0], ~refMem[addrList[0]], frameLen);  // Must replace the first word
    foreach (addrList[k]) begin
      readAndCheck(addrList[k]);
    end
  endtask

  // csN rises after 12 bits, the old word survives
  task automatic testAbortedWrite();
    writeWord(7'h2A, 8'h3C, 12);
    readAndCheck(7'h2A);
  endtask

  task automatic testExtraPulses();
    writeWord(7'h11, 8'h5A, frameLen + 4);  // Four clocks past bit 16
    readAndCheck(7'h11);
    writeWord(7'h12, 8'hC3, frameLen);      // Next frame as usual
    readAndCheck(7'h12);
  endtask

  // runFrame flags any enable during a write
  task automatic testWriteEnableLow();
    writeWord(7'h7F, 8'hFF, frameLen);
    writeWord(7'h00, 8'h81, frameLen);
    readAndCheck(7'h7F);
    readAndCheck(7'h00);
  endtask

  initial begin
    errors     = 0;
    timeouts   = 0;
    enableSeen = 1'b0;
    reset      = 1'b1;
    sclk       = 1'b0;
    csN        = 1'b1;
    mosi       = 1'b0;
    void'($urandom(3644));
    waitCycles(5);
    reset <= 1'b0;
    waitCycles(4);

    testIdleBus();
    testWriteRead();
    testRandomWrites();
    testAbortedWrite();
    testExtraPulses();
    testWriteEnableLow();

    $display("Closing report: %0d check errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: source/spiMemoryTop.sv
`timescale 1ns/1ps

module spiMemoryTop (
  input  logic clk,
  input  logic reset,
  input  logic sclk,
  input  logic csN,
  input  logic mosi,
  output logic miso,
  output logic misoEnable
);

  logic sclkRise;
  logic sclkFall;
  logic csActive;
  logic mosiSync;

  logic [spiPkg::countWidth-1:0] bitCount;
  memPkg::memWord                shiftValue;  // Also carries the address bits
  memPkg::memWord                readWord;

  spiCtrlIf ctrlBus ();

  // Pins into the clk domain
  spiInputSync spiInputSync_inst (
    .clk      (clk),
    .reset    (reset),
    .sclk     (sclk),
    .csN      (csN),
    .mosi     (mosi),
    .sclkRise (sclkRise),
    .sclkFall (sclkFall),
    .csActive (csActive),
    .mosiSync (mosiSync)
  );

  bitCounter bitCounter_inst (
    .clk      (clk),
    .reset    (reset),
    .sclkRise (sclkRise),
    .csActive (csActive),
    .bitCount (bitCount)
  );

  spiFsm spiFsm_inst (
    .clk      (clk),
    .reset    (reset),
    .csActive (csActive),
    .sclkRise (sclkRise),
    .sclkFall (sclkFall),
    .bitCount (bitCount),
    .flagBit  (shiftValue[0]),  // R/W flag after rise 8
    .ctrl     (ctrlBus.ctrl)
  );

  shiftRegister shiftRegister_inst (
    .clk        (clk),
    .reset      (reset),
    .sclkRise   (sclkRise),
    .sclkFall   (sclkFall),
    .mosiSync   (mosiSync),
    .ctrl       (ctrlBus.datapath),
    .loadWord   (readWord),
    .shiftValue (shiftValue),
    .miso       (miso)
  );

  dataMemory dataMemory_inst (
    .clk        (clk),
    .reset      (reset),
    .ctrl       (ctrlBus.datapath),
    .shiftValue (shiftValue),
    .readWord   (readWord)
  );

  assign misoEnable = ctrlBus.misoEnable;  // Pad enable

endmodule

// File: source/spiFsm.sv
`timescale 1ns/1ps

module spiFsm (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          csActive,
  input  logic                          sclkRise,
  input  logic                          sclkFall,
  input  logic [spiPkg::countWidth-1:0] bitCount,
  input  logic                          flagBit,   // LSB of shift register
  spiCtrlIf.ctrl                        ctrl
);

  spiPkg::spiState state;
  spiPkg::spiState nextState;

  logic addrDone;   // Count reached 7
  logic flagDone;   // Count reached 8
  logic frameDone;  // Count reached 16

  assign addrDone  = bitCount == spiPkg::countWidth'(spiPkg::addrBits);
  assign flagDone  = bitCount == spiPkg::countWidth'(spiPkg::addrBits + 1);
  assign frameDone = bitCount == spiPkg::countWidth'(spiPkg::frameBits);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= spiPkg::idle;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      spiPkg::idle: begin
        if (csActive) nextState = spiPkg::address;
      end
      spiPkg::address: begin
        if (addrDone) nextState = spiPkg::rwFlag;  // Latch fires this cycle
      end
      spiPkg::rwFlag: begin
        // Flag bit is already in the LSB when the count shows 8
        if (flagDone) begin
          nextState = flagBit ? spiPkg::readLoad : spiPkg::writeData;
        end
      end
      spiPkg::readLoad: begin
        if (sclkFall) begin
          nextState = spiPkg::readShift;
        end else if (sclkRise) begin
          nextState = spiPkg::done;  // Missed the fall, give up on this frame
        end
      end
      spiPkg::readShift: begin
        if (sclkFall && frameDone) nextState = spiPkg::done;  // Fall after rise 16
      end
      spiPkg::writeData: begin
        if (frameDone) nextState = spiPkg::writeCommit;
      end
      spiPkg::writeCommit: nextState = spiPkg::done;
      spiPkg::done: nextState = spiPkg::done;  // Park until deselect
      default: nextState = spiPkg::idle;
    endcase

    // Early deselect aborts any frame, write included
    if (!csActive) nextState = spiPkg::idle;
  end

  // Strobes decoded straight from state
  assign ctrl.addrLatch  = (state == spiPkg::address) && addrDone;
  assign ctrl.srLoad     = (state == spiPkg::readLoad) && sclkFall;
  assign ctrl.shiftOutEn = state == spiPkg::readShift;
  assign ctrl.memWrite   = state == spiPkg::writeCommit;  // One cycle after count 16

  // Output enable comes up with the load and drops on deselect at once
  assign ctrl.misoEnable = csActive && (ctrl.srLoad || state == spiPkg::readShift);

  // Double write would repeat the store with the same data
  writeOneCycle: assert property (
    @(posedge clk) disable iff (reset)
    ctrl.memWrite |=> !ctrl.memWrite
  ) else $error("memWrite longer than one cycle");

  // Read and write paths are exclusive within a frame
  writeNotDriving: assert property (
    @(posedge clk) disable iff (reset)
    !(ctrl.memWrite && ctrl.misoEnable)
  ) else $error("memWrite while miso is driven");

endmodule

// File: source/dataMemory.sv
`timescale 1ns/1ps

module dataMemory (
  input  logic           clk,
  input  logic           reset,
  spiCtrlIf.datapath     ctrl,
  input  memPkg::memWord shiftValue,
  output memPkg::memWord readWord
);

  memPkg::memWord storage [memPkg::memDepth];
  memPkg::memAddr addrReg;  // Held for the rest of the frame

  // Address latch
  always_ff @(posedge clk) begin
    if (reset) begin
      addrReg <= '0;
    end else if (ctrl.addrLatch) begin
      addrReg <= shiftValue[$bits(memPkg::memAddr)-1:0];  // Low 7 bits
    end
  end

  // Storage array, no reset
  always_ff @(posedge clk) begin
    if (ctrl.memWrite) begin
      storage[addrReg] <= shiftValue;
    end
  end

  assign readWord = storage[addrReg];  // Async read feeds srLoad

  // A write in the latch cycle would use the previous frame's address
  latchBeforeWrite: assert property (
    @(posedge clk) disable iff (reset)
    !(ctrl.memWrite && ctrl.addrLatch)
  ) else $error("memWrite together with addrLatch");

endmodule

// File: source/shiftRegister.sv
`timescale 1ns/1ps

module shiftRegister (
  input  logic            clk,
  input  logic            reset,
  input  logic            sclkRise,
  input  logic            sclkFall,
  input  logic            mosiSync,
  spiCtrlIf.datapath      ctrl,
  input  memPkg::memWord  loadWord,
  output memPkg::memWord  shiftValue,
  output logic            miso
);

  memPkg::memWord shiftData;

  // Rises sample mosi while receiving.
  // Once the FSM hands over miso, falls move the word out instead.
  always_ff @(posedge clk) begin
    if (reset) begin
      shiftData <= '0;
    end else if (ctrl.srLoad) begin
      shiftData <= loadWord;  // Takes the place of the fall shift
    end else if (ctrl.shiftOutEn) begin
      if (sclkFall) begin
        shiftData <= {shiftData[memPkg::wordBits-2:0], 1'b0};
      end
    end else if (sclkRise) begin
      shiftData <= {shiftData[memPkg::wordBits-2:0], mosiSync};  // New bit at LSB
    end
  end

  assign shiftValue = shiftData;
  assign miso       = shiftData[memPkg::wordBits-1];  // MSB first

endmodule

// File: source/bitCounter.sv
`timescale 1ns/1ps

module bitCounter (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          sclkRise,
  input  logic                          csActive,
  output logic [spiPkg::countWidth-1:0] bitCount
);

  always_ff @(posedge clk) begin
    if (reset) begin
      bitCount <= '0;
    end else if (!csActive) begin
      bitCount <= '0;  // New frame starts from zero
    // Parks one past the last frame bit
    end else if (sclkRise && bitCount != spiPkg::countWidth'(spiPkg::frameBits + 1)) begin
      bitCount <= bitCount + 1'b1;
    end
  end

  // Extra clocks past bit 16 must not wrap the count back into the frame
  countSaturates: assert property (
    @(posedge clk) disable iff (reset)
    bitCount <= spiPkg::countWidth'(spiPkg::frameBits + 1)
  ) else $error("bitCount above saturation value");

endmodule

// File: source/spiInputSync.sv
`timescale 1ns/1ps

module spiInputSync (
  input  logic clk,
  input  logic reset,
  input  logic sclk,
  input  logic csN,
  input  logic mosi,
  output logic sclkRise,
  output logic sclkFall,
  output logic csActive,
  output logic mosiSync
);

  logic [1:0] sclkMeta;  // Index 1 is the settled stage
  logic [1:0] csNMeta;
  logic [1:0] mosiMeta;
  logic       sclkPrev;  // Settled sclk one cycle back

  // Two flops per pin, reset to bus idle levels
  always_ff @(posedge clk) begin
    if (reset) begin
      sclkMeta <= 2'b00;  // Mode 0 idles low
      csNMeta  <= 2'b11;  // Deselected
      mosiMeta <= 2'b00;
      sclkPrev <= 1'b0;
    end else begin
      sclkMeta <= {sclkMeta[0], sclk};
      csNMeta  <= {csNMeta[0], csN};
      mosiMeta <= {mosiMeta[0], mosi};
      sclkPrev <= sclkMeta[1];
    end
  end

  // Edge pulses last exactly one clk cycle
  assign sclkRise = sclkMeta[1] & ~sclkPrev;
  assign sclkFall = ~sclkMeta[1] & sclkPrev;

  assign csActive = ~csNMeta[1];  // Active-high inside the design
  assign mosiSync = mosiMeta[1];

endmodule

// File: source/spiCtrlIf.sv
`timescale 1ns/1ps

// Steering strobes from the frame FSM to the datapath
interface spiCtrlIf;

  logic addrLatch;   // Capture address from shift register
  logic srLoad;      // Parallel load of read word
  logic shiftOutEn;  // Falls shift data toward miso
  logic memWrite;    // Store shift register contents
  logic misoEnable;  // Slave owns miso

  // FSM side
  modport ctrl (
    output addrLatch,
    output srLoad,
    output shiftOutEn,
    output memWrite,
    output misoEnable
  );

  // Shift register, memory and top-level pin
  modport datapath (
    input addrLatch,
    input srLoad,
    input shiftOutEn,
    input memWrite,
    input misoEnable
  );

endinterface

// File: source/memPkg.sv
package memPkg;

  // Storage geometry
  localparam int memDepth = 128;
  localparam int wordBits = 8;

  // Address wide enough for every word
  typedef logic [$clog2(memDepth)-1:0] memAddr;

  // One stored byte
  typedef logic [wordBits-1:0] memWord;

endpackage

// File: source/spiPkg.sv
package spiPkg;

  // Frame layout, MSB first
  localparam int addrBits  = 7;   // Bits 1 to 7
  localparam int frameBits = 16;  // Address, flag, data byte

  // Count runs 0..16, then parks one above the frame length
  localparam int countWidth = 5;

  // Controller states, in frame order
  typedef enum logic [2:0] {
    idle,         // Chip select high
    address,      // Collecting address bits
    rwFlag,       // Waiting for bit 8
    readLoad,     // Waiting for the fall after rise 8
    readShift,    // Driving data bits out on miso
    writeData,    // Collecting data bits from mosi
    writeCommit,  // Single memory write cycle
    done          // Rest of frame ignored
  } spiState;

endpackage
